// ==== Bender.yml ====
package:
  name: core_ctrl

sources:
  - hdl/core_ctrl_pkg.sv
  - hdl/ctrl_fsm.sv
  - hdl/debug_status.sv
  - hdl/pc_gen.sv
  - hdl/core_ctrl_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/core_ctrl_checker.sv
      - tests/core_ctrl_properties.sv
      - tests/tb_core_ctrl.sv

// ==== hdl/core_ctrl_pkg.sv ====
package core_ctrl_pkg;

  ////////////////////////////////////////
  // Address types
  ////////////////////////////////////////

  typedef logic [31:0] addr_t;  // Fetch or target address

  localparam addr_t BOOT_ADDR  = 32'h0000_0080;  // First fetch after boot
  localparam addr_t DEBUG_ADDR = 32'h0000_0800;  // Debug entry point
  localparam addr_t PC_STEP    = 32'd4;          // Sequential increment

  ////////////////////////////////////////
  // State machine encodings
  ////////////////////////////////////////

  // Main controller
  typedef enum logic [1:0] {
    CTRL_RESET      = 2'd0,
    CTRL_BOOT_SET   = 2'd1,
    CTRL_FUNCTIONAL = 2'd2
  } ctrl_state_e;

  // Debug status is one-hot so the bits drive the outputs directly
  localparam int HAVERESET_IDX = 0;
  localparam int RUNNING_IDX   = 1;
  localparam int HALTED_IDX    = 2;

  typedef enum logic [2:0] {
    HAVERESET = 3'b001 << HAVERESET_IDX,
    RUNNING   = 3'b001 << RUNNING_IDX,
    HALTED    = 3'b001 << HALTED_IDX
  } debug_state_e;

  ////////////////////////////////////////
  // Fetch control
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT   = 3'd0,
    PC_BRANCH = 3'd1,
    PC_JUMP   = 3'd2,
    PC_DEBUG  = 3'd3,
    PC_DRET   = 3'd4
  } pc_mux_e;

  // Control transfer kind seen in ID
  typedef enum logic [1:0] {
    XFER_NONE   = 2'd0,
    XFER_BRANCH = 2'd1,
    XFER_JAL    = 2'd2,
    XFER_JALR   = 2'd3
  } xfer_e;

endpackage

// ==== hdl/core_ctrl_top.sv ====
`timescale 1ns/1ps

module core_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 jr_stall_i,
  input  logic                 instr_valid_id_i,
  input  core_ctrl_pkg::xfer_e xfer_insn_i,
  input  core_ctrl_pkg::addr_t jump_target_i,
  input  logic                 branch_taken_ex_i,
  input  core_ctrl_pkg::addr_t branch_target_i,
  input  logic                 dret_insn_i,
  input  logic                 debug_req_i,
  output logic                 instr_req_o,
  output core_ctrl_pkg::addr_t fetch_addr_o,
  output logic                 halt_if_o,
  output logic                 halt_id_o,
  output logic                 is_decoding_o,
  output logic                 debug_mode_o,
  output logic                 debug_havereset_o,
  output logic                 debug_running_o,
  output logic                 debug_halted_o
);

  logic                   pc_set;
  core_ctrl_pkg::pc_mux_e pc_mux;
  logic                   debug_enter;    // Controller to status block
  logic                   debug_exit;
  logic                   boot;
  logic                   debug_pending;  // Status block back to controller

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .jr_stall_i        (jr_stall_i),
    .instr_valid_id_i  (instr_valid_id_i),
    .xfer_insn_i       (xfer_insn_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .dret_insn_i       (dret_insn_i),
    .debug_pending_i   (debug_pending),
    .debug_mode_i      (debug_mode_o),
    .instr_req_o       (instr_req_o),
    .pc_set_o          (pc_set),
    .pc_mux_o          (pc_mux),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .is_decoding_o     (is_decoding_o),
    .debug_enter_o     (debug_enter),
    .debug_exit_o      (debug_exit),
    .boot_o            (boot)
  );

  debug_status u_debug_status (
    .clk               (clk),
    .rst_n             (rst_n),
    .debug_req_i       (debug_req_i),
    .debug_enter_i     (debug_enter),
    .debug_exit_i      (debug_exit),
    .boot_i            (boot),
    .debug_pending_o   (debug_pending),
    .debug_mode_o      (debug_mode_o),
    .debug_havereset_o (debug_havereset_o),
    .debug_running_o   (debug_running_o),
    .debug_halted_o    (debug_halted_o)
  );

  ////////////////////////////////////////
  // Fetch address
  ////////////////////////////////////////

  pc_gen u_pc_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set),
    .pc_mux_i        (pc_mux),
    .instr_req_i     (instr_req_o),
    .halt_if_i       (halt_if_o),
    .branch_target_i (branch_target_i),
    .jump_target_i   (jump_target_i),
    .fetch_addr_o    (fetch_addr_o)
  );

endmodule

// ==== hdl/ctrl_fsm.sv ====
`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,     // Start fetching after reset
  input  logic                   jr_stall_i,         // Register jump operand not ready
  input  logic                   instr_valid_id_i,   // Valid instruction in ID
  input  core_ctrl_pkg::xfer_e   xfer_insn_i,        // Transfer kind decoded in ID
  input  logic                   branch_taken_ex_i,  // Branch resolved taken in EX
  input  logic                   dret_insn_i,        // dret decoded in ID
  input  logic                   debug_pending_i,    // Sticky debug request
  input  logic                   debug_mode_i,       // Core is in debug mode
  output logic                   instr_req_o,
  output logic                   pc_set_o,           // Load fetch address from pc_mux_o
  output core_ctrl_pkg::pc_mux_e pc_mux_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output logic                   is_decoding_o,
  output logic                   debug_enter_o,      // Single-cycle pulse
  output logic                   debug_exit_o,       // Single-cycle pulse
  output logic                   boot_o              // Next state is boot set
);

  core_ctrl_pkg::ctrl_state_e state_q, state_n;

  logic jump_in_dec;  // JAL or JALR in ID
  logic dret_in_dec;  // dret in ID honoured only in debug mode

  assign jump_in_dec = instr_valid_id_i &&
                       ((xfer_insn_i == core_ctrl_pkg::XFER_JAL) ||
                        (xfer_insn_i == core_ctrl_pkg::XFER_JALR));
  assign dret_in_dec = instr_valid_id_i && dret_insn_i && debug_mode_i;

  ////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////

  always_comb begin
    state_n       = state_q;  // Hold by default
    instr_req_o   = 1'b1;
    pc_set_o      = 1'b0;
    pc_mux_o      = core_ctrl_pkg::PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    is_decoding_o = 1'b0;
    debug_enter_o = 1'b0;
    debug_exit_o  = 1'b0;

    case (state_q)
      core_ctrl_pkg::CTRL_RESET: begin
        instr_req_o = 1'b0;  // No fetch until enabled
        if (fetch_enable_i) begin
          state_n = core_ctrl_pkg::CTRL_BOOT_SET;
        end
      end

      core_ctrl_pkg::CTRL_BOOT_SET: begin
        pc_set_o = 1'b1;  // Boot address loaded once
        pc_mux_o = core_ctrl_pkg::PC_BOOT;
        state_n  = core_ctrl_pkg::CTRL_FUNCTIONAL;
      end

      core_ctrl_pkg::CTRL_FUNCTIONAL: begin
        is_decoding_o = 1'b1;
        // One redirect per cycle in priority order
        if (branch_taken_ex_i) begin
          pc_set_o  = 1'b1;
          pc_mux_o  = core_ctrl_pkg::PC_BRANCH;
          halt_id_o = 1'b1;  // ID holds a wrong-path instruction
        end else if (debug_pending_i && !debug_mode_i) begin
          pc_set_o      = 1'b1;
          pc_mux_o      = core_ctrl_pkg::PC_DEBUG;
          debug_enter_o = 1'b1;
        end else if (jump_in_dec) begin
          halt_if_o = 1'b1;  // Stop sequential fetch behind the jump
          pc_mux_o  = core_ctrl_pkg::PC_JUMP;
          pc_set_o  = !jr_stall_i;  // Wait for the jump operand
        end else if (dret_in_dec) begin
          pc_set_o     = 1'b1;
          pc_mux_o     = core_ctrl_pkg::PC_DRET;
          debug_exit_o = 1'b1;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_n     = core_ctrl_pkg::CTRL_RESET;  // Recover from unused code
      end
    endcase
  end

  assign boot_o = (state_n == core_ctrl_pkg::CTRL_BOOT_SET);

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= core_ctrl_pkg::CTRL_RESET;
    end else begin
      state_q <= state_n;
    end
  end

endmodule

// ==== hdl/debug_status.sv ====
`timescale 1ns/1ps

module debug_status (
  input  logic clk,
  input  logic rst_n,
  input  logic debug_req_i,        // External request, may be a single pulse
  input  logic debug_enter_i,      // Controller takes the request
  input  logic debug_exit_i,       // Controller executes dret
  input  logic boot_i,             // Controller is about to boot
  output logic debug_pending_o,
  output logic debug_mode_o,
  output logic debug_havereset_o,
  output logic debug_running_o,
  output logic debug_halted_o
);

  logic debug_req_q;   // Sticky request
  logic debug_mode_q;
  logic debug_mode_n;

  core_ctrl_pkg::debug_state_e status_q, status_n;

  ////////////////////////////////////////
  // Request and mode flag
  ////////////////////////////////////////

  // Kept across boot until debug mode is reached
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q <= 1'b0;
    end else if (debug_req_i) begin
      debug_req_q <= 1'b1;
    end else if (debug_mode_q) begin
      debug_req_q <= 1'b0;  // Request served
    end
  end

  always_comb begin
    debug_mode_n = debug_mode_q;
    if (debug_enter_i) debug_mode_n = 1'b1;
    else if (debug_exit_i) debug_mode_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) debug_mode_q <= 1'b0;
    else        debug_mode_q <= debug_mode_n;
  end

  assign debug_pending_o = debug_req_q;
  assign debug_mode_o    = debug_mode_q;

  ////////////////////////////////////////
  // Status machine
  ////////////////////////////////////////

  // Tracks the next mode value so status and flag change on the same edge
  always_comb begin
    status_n = status_q;
    case (status_q)
      core_ctrl_pkg::HAVERESET: begin
        if (debug_mode_n) status_n = core_ctrl_pkg::HALTED;
        else if (boot_i)  status_n = core_ctrl_pkg::RUNNING;
      end
      core_ctrl_pkg::RUNNING: if (debug_mode_n)  status_n = core_ctrl_pkg::HALTED;
      core_ctrl_pkg::HALTED:  if (!debug_mode_n) status_n = core_ctrl_pkg::RUNNING;
      default: status_n = core_ctrl_pkg::HAVERESET;  // Illegal one-hot value
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) status_q <= core_ctrl_pkg::HAVERESET;
    else        status_q <= status_n;
  end

  assign debug_havereset_o = status_q[core_ctrl_pkg::HAVERESET_IDX];
  assign debug_running_o   = status_q[core_ctrl_pkg::RUNNING_IDX];
  assign debug_halted_o    = status_q[core_ctrl_pkg::HALTED_IDX];

endmodule

// ==== hdl/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_set_i,         // Redirect this cycle
  input  core_ctrl_pkg::pc_mux_e pc_mux_i,         // Redirect target select
  input  logic                   instr_req_i,      // Fetch is active
  input  logic                   halt_if_i,        // Hold sequential fetch
  input  core_ctrl_pkg::addr_t   branch_target_i,
  input  core_ctrl_pkg::addr_t   jump_target_i,
  output core_ctrl_pkg::addr_t   fetch_addr_o
);

  core_ctrl_pkg::addr_t fetch_addr_q;
  core_ctrl_pkg::addr_t fetch_addr_n;
  core_ctrl_pkg::addr_t target;       // Selected redirect address
  core_ctrl_pkg::addr_t ret_addr_q;   // Return address for dret

  logic save_ret;

  ////////////////////////////////////////
  // Target select
  ////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      core_ctrl_pkg::PC_BOOT:   target = core_ctrl_pkg::BOOT_ADDR;
      core_ctrl_pkg::PC_BRANCH: target = branch_target_i;
      core_ctrl_pkg::PC_JUMP:   target = jump_target_i;
      core_ctrl_pkg::PC_DEBUG:  target = core_ctrl_pkg::DEBUG_ADDR;
      core_ctrl_pkg::PC_DRET:   target = ret_addr_q;
      default:                  target = core_ctrl_pkg::BOOT_ADDR;
    endcase
  end

  // Redirect first, then sequential step, else hold
  always_comb begin
    if (pc_set_i) begin
      fetch_addr_n = target;
    end else if (instr_req_i && !halt_if_i) begin
      fetch_addr_n = fetch_addr_q + core_ctrl_pkg::PC_STEP;
    end else begin
      fetch_addr_n = fetch_addr_q;
    end
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= core_ctrl_pkg::BOOT_ADDR;
    end else begin
      fetch_addr_q <= fetch_addr_n;
    end
  end

  // Debug entry saves the address that would have been fetched
  assign save_ret = pc_set_i && (pc_mux_i == core_ctrl_pkg::PC_DEBUG);

  always_ff @(posedge clk) begin
    if (save_ret) begin
      ret_addr_q <= fetch_addr_q;
    end
  end

  assign fetch_addr_o = fetch_addr_q;

endmodule

// ==== list.f ====
hdl/core_ctrl_pkg.sv
hdl/ctrl_fsm.sv
hdl/debug_status.sv
hdl/pc_gen.sv
hdl/core_ctrl_top.sv
tests/tb_clk_gen.sv
tests/core_ctrl_checker.sv
tests/core_ctrl_properties.sv
tests/tb_core_ctrl.sv

// ==== tests/core_ctrl_checker.sv ====
`timescale 1ns/1ps

module core_ctrl_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_enable_i,
  input  logic                 jr_stall_i,
  input  logic                 instr_valid_id_i,
  input  core_ctrl_pkg::xfer_e xfer_insn_i,
  input  core_ctrl_pkg::addr_t jump_target_i,
  input  logic                 branch_taken_ex_i,
  input  core_ctrl_pkg::addr_t branch_target_i,
  input  logic                 dret_insn_i,
  input  logic                 debug_req_i,
  input  logic                 instr_req_i,       // DUT outputs from here on
  input  core_ctrl_pkg::addr_t fetch_addr_i,
  input  logic                 halt_if_i,
  input  logic                 halt_id_i,
  input  logic                 is_decoding_i,
  input  logic                 debug_mode_i,
  input  logic                 debug_havereset_i,
  input  logic                 debug_running_i,
  input  logic                 debug_halted_i,
  output int                   errors_o,
  output int                   checks_o
);

  core_ctrl_pkg::ctrl_state_e  m_state, n_state;    // Model of the controller
  core_ctrl_pkg::debug_state_e m_status, n_status;  // Model of the status bits
  core_ctrl_pkg::addr_t        m_pc, n_pc;
  core_ctrl_pkg::addr_t        m_ret, n_ret;        // Saved debug return address
  logic                        m_req, n_req;        // Sticky request
  logic                        m_mode, n_mode;
  logic                        e_req, e_hif, e_hid, e_dec;  // Expected control outputs
  int                          error_count = 0;
  int                          check_count = 0;

  assign errors_o = error_count;
  assign checks_o = check_count;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic void ref_model(
    input core_ctrl_pkg::ctrl_state_e st, input logic req, mode,
    input core_ctrl_pkg::debug_state_e stat, input core_ctrl_pkg::addr_t pc, ret,
    input logic fe, stall, valid, input core_ctrl_pkg::xfer_e xfer, input logic br,
    input core_ctrl_pkg::addr_t bt, jt, input logic dret, dreq,
    output logic req_o, hif, hid, dec,
    output core_ctrl_pkg::ctrl_state_e st_n, output logic req_n, mode_n,
    output core_ctrl_pkg::debug_state_e stat_n, output core_ctrl_pkg::addr_t pc_n, ret_n
  );
    logic                 set;
    logic                 enter;
    logic                 leave;
    logic                 jump;
    core_ctrl_pkg::addr_t tgt;
    req_o = 1'b1;
    hif   = 1'b0;
    hid   = 1'b0;
    dec   = 1'b0;
    set   = 1'b0;
    enter = 1'b0;
    leave = 1'b0;
    tgt   = core_ctrl_pkg::BOOT_ADDR;
    st_n  = st;
    jump  = valid && (xfer == core_ctrl_pkg::XFER_JAL || xfer == core_ctrl_pkg::XFER_JALR);
    case (st)
      core_ctrl_pkg::CTRL_RESET: begin
        req_o = 1'b0;                                   // Idle until enabled
        if (fe) st_n = core_ctrl_pkg::CTRL_BOOT_SET;
      end
      core_ctrl_pkg::CTRL_BOOT_SET: begin
        set  = 1'b1;                                    // Boot address for one cycle
        st_n = core_ctrl_pkg::CTRL_FUNCTIONAL;
      end
      default: begin
        dec = 1'b1;
        // One redirect per cycle
        if (br) begin
          set = 1'b1;
          tgt = bt;
          hid = 1'b1;
        end else if (req && !mode) begin
          set   = 1'b1;
          tgt   = core_ctrl_pkg::DEBUG_ADDR;
          enter = 1'b1;
        end else if (jump) begin
          hif = 1'b1;
          set = !stall;                                 // Held back by jr stall
          tgt = jt;
        end else if (valid && dret && mode) begin
          set   = 1'b1;
          tgt   = ret;
          leave = 1'b1;
        end
      end
    endcase
    if (set) pc_n = tgt;
    else if (req_o && !hif) pc_n = pc + core_ctrl_pkg::PC_STEP;
    else pc_n = pc;
    ret_n  = enter ? pc : ret;
    mode_n = enter ? 1'b1 : (leave ? 1'b0 : mode);
    req_n  = dreq ? 1'b1 : (mode ? 1'b0 : req);        // Cleared while in debug
    if (mode_n) stat_n = core_ctrl_pkg::HALTED;
    else if (stat == core_ctrl_pkg::HAVERESET && st_n != core_ctrl_pkg::CTRL_BOOT_SET)
      stat_n = core_ctrl_pkg::HAVERESET;
    else stat_n = core_ctrl_pkg::RUNNING;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected, actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  ////////////////////////////////////////
  // Compare every cycle
  ////////////////////////////////////////

  // Inputs and outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      m_state  = core_ctrl_pkg::CTRL_RESET;
      m_status = core_ctrl_pkg::HAVERESET;
      m_pc     = core_ctrl_pkg::BOOT_ADDR;
      m_ret    = core_ctrl_pkg::BOOT_ADDR;  // Not observable before a debug entry
      m_req    = 1'b0;
      m_mode   = 1'b0;
    end
    ref_model(m_state, m_req, m_mode, m_status, m_pc, m_ret,
              fetch_enable_i, jr_stall_i, instr_valid_id_i, xfer_insn_i, branch_taken_ex_i,
              branch_target_i, jump_target_i, dret_insn_i, debug_req_i,
              e_req, e_hif, e_hid, e_dec, n_state, n_req, n_mode, n_status, n_pc, n_ret);
    check_value("instr_req_o", e_req, instr_req_i);
    check_value("fetch_addr_o", m_pc, fetch_addr_i);
    check_value("halt_if_o", e_hif, halt_if_i);
    check_value("halt_id_o", e_hid, halt_id_i);
    check_value("is_decoding_o", e_dec, is_decoding_i);
    check_value("debug_mode_o", m_mode, debug_mode_i);
    check_value("debug_havereset_o", m_status[core_ctrl_pkg::HAVERESET_IDX], debug_havereset_i);
    check_value("debug_running_o", m_status[core_ctrl_pkg::RUNNING_IDX], debug_running_i);
    check_value("debug_halted_o", m_status[core_ctrl_pkg::HALTED_IDX], debug_halted_i);
    if (rst_n) begin  // Advance to the state after the next rising edge
      m_state  = n_state;
      m_status = n_status;
      m_pc     = n_pc;
      m_ret    = n_ret;
      m_req    = n_req;
      m_mode   = n_mode;
    end
  end

endmodule

// ==== tests/core_ctrl_properties.sv ====
`timescale 1ns/1ps

module core_ctrl_properties (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   pc_set_i,
  input core_ctrl_pkg::pc_mux_e pc_mux_i,
  input logic                   debug_mode_i,
  input logic                   halt_if_i,
  input logic                   halt_id_i,
  input logic                   havereset_i,
  input logic                   running_i,
  input logic                   halted_i
);

  int fail_count = 0;  // Failed assertions so far

  // dret redirect only from debug mode
  a_dret_in_debug: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_set_i && pc_mux_i == core_ctrl_pkg::PC_DRET) |-> debug_mode_i)
    else begin
      $error("dret redirect outside debug mode");
      fail_count++;
    end

  a_status_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot({havereset_i, running_i, halted_i}))
    else begin
      $error("debug status bits not one-hot");
      fail_count++;
    end

  a_halts_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(halt_if_i && halt_id_i))
    else begin
      $error("halt_if_o and halt_id_o high together");
      fail_count++;
    end

endmodule

bind core_ctrl_top core_ctrl_properties u_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .pc_set_i     (pc_set),
  .pc_mux_i     (pc_mux),
  .debug_mode_i (debug_mode_o),
  .halt_if_i    (halt_if_o),
  .halt_id_i    (halt_id_o),
  .havereset_i  (debug_havereset_o),
  .running_i    (debug_running_o),
  .halted_i     (debug_halted_o)
);

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 50;  // 100 ns clock
  localparam int RESET_CYCLES   = 3;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;                       // Reset active from time zero
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;                      // Released on a rising edge
  end

endmodule

// ==== tests/tb_core_ctrl.sv ====
`timescale 1ns/1ps

module tb_core_ctrl;

  localparam int RANDOM_CYCLES   = 400;
  localparam int DIRECTED_CYCLES = 200;  // Upper bound of the directed tests
  localparam int MARGIN_CYCLES   = 100;
  localparam int WATCHDOG_NS     = (RANDOM_CYCLES + DIRECTED_CYCLES + MARGIN_CYCLES) * 100;

  logic                 clk, rst_n;
  logic                 fetch_enable, jr_stall, instr_valid_id, branch_taken_ex;
  logic                 dret_insn, debug_req;
  core_ctrl_pkg::xfer_e xfer_insn;
  core_ctrl_pkg::addr_t jump_target, branch_target, fetch_addr;
  logic                 instr_req, halt_if, halt_id, is_decoding, debug_mode;
  logic                 debug_havereset, debug_running, debug_halted;
  int                   check_errors, check_count;
  int                   wait_fails = 0;  // Local waits that ran out
  int                   tests_run = 0;
  int                   tests_failed = 0;
  int                   errors_at_start;
  int                   stall_len;
  string                current_test;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  core_ctrl_top UUT (
    .clk(clk), .rst_n(rst_n), .fetch_enable_i(fetch_enable), .jr_stall_i(jr_stall),
    .instr_valid_id_i(instr_valid_id), .xfer_insn_i(xfer_insn), .jump_target_i(jump_target),
    .branch_taken_ex_i(branch_taken_ex), .branch_target_i(branch_target),
    .dret_insn_i(dret_insn), .debug_req_i(debug_req), .instr_req_o(instr_req),
    .fetch_addr_o(fetch_addr), .halt_if_o(halt_if), .halt_id_o(halt_id),
    .is_decoding_o(is_decoding), .debug_mode_o(debug_mode),
    .debug_havereset_o(debug_havereset), .debug_running_o(debug_running),
    .debug_halted_o(debug_halted)
  );

  core_ctrl_checker u_checker (
    .clk(clk), .rst_n(rst_n), .fetch_enable_i(fetch_enable), .jr_stall_i(jr_stall),
    .instr_valid_id_i(instr_valid_id), .xfer_insn_i(xfer_insn), .jump_target_i(jump_target),
    .branch_taken_ex_i(branch_taken_ex), .branch_target_i(branch_target),
    .dret_insn_i(dret_insn), .debug_req_i(debug_req), .instr_req_i(instr_req),
    .fetch_addr_i(fetch_addr), .halt_if_i(halt_if), .halt_id_i(halt_id),
    .is_decoding_i(is_decoding), .debug_mode_i(debug_mode),
    .debug_havereset_i(debug_havereset), .debug_running_i(debug_running),
    .debug_halted_i(debug_halted), .errors_o(check_errors), .checks_o(check_count)
  );

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  function automatic core_ctrl_pkg::addr_t rand_addr();
    return $urandom & 32'hffff_fffc;  // Word aligned
  endfunction

  // Compare mismatches, failed waits and failed assertions
  function automatic int total_errors();
    return check_errors + wait_fails + UUT.u_properties.fail_count;
  endfunction

  // Quiet pipeline with fetch enable left as it is
  task automatic drive_idle();
    jr_stall        <= 1'b0;
    instr_valid_id  <= 1'b0;
    xfer_insn       <= core_ctrl_pkg::XFER_NONE;
    branch_taken_ex <= 1'b0;
    dret_insn       <= 1'b0;
    debug_req       <= 1'b0;
  endtask

  task automatic issue_dret();
    @(posedge clk);
    instr_valid_id <= 1'b1;
    dret_insn      <= 1'b1;
    @(posedge clk);
    drive_idle();
  endtask

  task automatic wait_status(input logic halted, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (debug_halted !== halted && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (debug_halted !== halted) begin
      $display("Debug status did not reach %s within %0d cycles",
               halted ? "halted" : "running", limit);
      wait_fails++;
    end
  endtask

  task automatic wait_boot(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (is_decoding !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (is_decoding !== 1'b1) begin
      $display("Controller did not start decoding within %0d cycles", limit);
      wait_fails++;
    end
  endtask

  task automatic start_test(input string name);
    current_test    = name;
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    int n;
    @(posedge clk);  // Last falling edge compare is in
    n = total_errors() - errors_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("Test %s %s (%0d errors)", current_test, (n == 0) ? "passed" : "failed", n);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(32'h29be7906));
    fetch_enable    = 1'b0;
    jr_stall        = 1'b0;
    instr_valid_id  = 1'b0;
    xfer_insn       = core_ctrl_pkg::XFER_NONE;
    jump_target     = '0;
    branch_taken_ex = 1'b0;
    branch_target   = '0;
    dret_insn       = 1'b0;
    debug_req       = 1'b0;

    // Boot with a debug request seen before it
    start_test("reset_boot");
    while (rst_n !== 1'b1) @(negedge clk);
    repeat (4) @(posedge clk);  // Outputs stay inactive
    debug_req <= 1'b1;
    @(posedge clk);
    debug_req <= 1'b0;
    @(posedge clk);
    fetch_enable <= 1'b1;
    wait_boot(10);
    wait_status(1'b1, 10);
    repeat (3) @(posedge clk);
    issue_dret();
    wait_status(1'b0, 10);
    end_test();

    start_test("seq_fetch");
    repeat (8) @(posedge clk);
    end_test();

    // Branch against jump and then against a debug request
    start_test("branch");
    repeat (4) begin
      @(posedge clk);
      branch_taken_ex <= 1'b1;
      branch_target   <= rand_addr();
      instr_valid_id  <= 1'b1;
      xfer_insn       <= core_ctrl_pkg::XFER_JAL;
      jump_target     <= rand_addr();
      @(posedge clk);
      drive_idle();
    end
    @(posedge clk);
    branch_taken_ex <= 1'b1;
    branch_target   <= rand_addr();
    debug_req       <= 1'b1;
    @(posedge clk);
    drive_idle();
    wait_status(1'b1, 10);
    issue_dret();
    wait_status(1'b0, 10);
    end_test();

    start_test("jump_stall");
    for (int k = 0; k < 6; k++) begin
      stall_len = $urandom_range(1, 4);
      @(posedge clk);
      instr_valid_id <= 1'b1;
      xfer_insn      <= (k < 3) ? core_ctrl_pkg::XFER_JAL : core_ctrl_pkg::XFER_JALR;
      jump_target    <= rand_addr();
      jr_stall       <= 1'b1;
      repeat (stall_len) @(posedge clk);
      jr_stall <= 1'b0;  // Operand ready so the redirect goes out
      @(posedge clk);
      drive_idle();
      @(posedge clk);
    end
    end_test();

    // dret outside debug mode first and then a real entry and exit
    start_test("debug");
    issue_dret();
    repeat (2) @(posedge clk);
    debug_req <= 1'b1;
    @(posedge clk);
    debug_req <= 1'b0;
    wait_status(1'b1, 10);
    repeat (4) @(posedge clk);
    issue_dret();
    wait_status(1'b0, 10);
    end_test();

    start_test("random_mix");
    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      branch_taken_ex <= ($urandom_range(0, 7) == 0);
      branch_target   <= rand_addr();
      instr_valid_id  <= ($urandom_range(0, 1) == 1);
      xfer_insn       <= core_ctrl_pkg::xfer_e'($urandom_range(0, 3));
      jump_target     <= rand_addr();
      jr_stall        <= ($urandom_range(0, 2) == 0);
      dret_insn       <= ($urandom_range(0, 5) == 0);
      debug_req       <= ($urandom_range(0, 39) == 0);
    end
    @(posedge clk);
    drive_idle();
    repeat (3) @(negedge clk);
    if (debug_mode) begin  // Leave debug mode before the end
      issue_dret();
      wait_status(1'b0, 10);
    end
    end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, total_errors());
    if (total_errors() == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns without finishing the tests", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

endmodule
